//--- project.f
+incdir+tests
src/ooo_pkg.sv
src/dispatch_unit.sv
src/reservation_station.sv
src/execute_unit.sv
src/ooo_core_top.sv
tests/tb_ooo_core.sv

//--- run_sim.sh
#!/bin/sh
# compile with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" \
    && verilator --binary -j 0 --timescale 1ns/1ps --top-module tb_ooo_core -f project.f \
    && ./obj_dir/Vtb_ooo_core | tee /dev/stderr | grep -xF '** PASS **' > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- tests/tb_ooo_tasks.svh
task automatic check(input logic [xlen-1:0] got, input logic [xlen-1:0] exp, input string what);
    if (got !== exp) begin
        errors++;
        $display("ERROR %0t: %s is %0h, expected %0h", $time, what, got, exp);
    end
endtask

// x1 and x2 fixed and x3..x8 random mixes of lower registers
task automatic preload_regs();
    int pick;
    logic [reg_addr_w-1:0] ra;
    logic [reg_addr_w-1:0] rb;
    send(op_li1, 5'd1, 5'd0, 5'd0);
    send(op_add, 5'd2, 5'd1, 5'd1);
    for (int r = 3; r <= 8; r++) begin
        pick = {$random(seed)} % 3;
        ra = 5'(1 + {$random(seed)} % (r - 1));
        rb = 5'(1 + {$random(seed)} % (r - 1));
        case (pick)
            0:       send(op_mul, 5'(r), ra, rb);
            1:       send(op_sub, 5'(r), ra, rb);
            default: send(op_add, 5'(r), ra, rb);
        endcase
    end
    wait_idle();
endtask

task automatic timed_single(input alu_op_t op, input logic [reg_addr_w-1:0] rd,
                            input logic [reg_addr_w-1:0] ra, input logic [reg_addr_w-1:0] rb);
    send(op, rd, ra, rb);
    wait_idle();
    check(seen_cycle[last_tag] - sent_cycle[last_tag], 4, $sformatf("latency of %s", op.name()));
endtask

task automatic independent_ops();
    timed_single(op_add, 5'd9, 5'd3, 5'd4);
    timed_single(op_sub, 5'd10, 5'd1, 5'd2);
    timed_single(op_and, 5'd11, 5'd5, 5'd6);
    timed_single(op_or, 5'd12, 5'd7, 5'd8);
    timed_single(op_xor, 5'd13, 5'd3, 5'd8);
    // x10 holds minus one here
    timed_single(op_slt, 5'd14, 5'd10, 5'd1);
    timed_single(op_li1, 5'd15, 5'd0, 5'd0);
endtask

// gap 3 lands the reader on the producer's broadcast cycle
task automatic dependency_chains();
    for (int gap = 0; gap < 4; gap++) begin
        wait_idle();
        send(op_add, 5'd16, 5'd16, 5'd1);
        repeat (gap) @(negedge clk);
        send(op_add, 5'd17, 5'd16, 5'd16);
        send(op_add, 5'd16, 5'd17, 5'd2);
    end
    wait_idle();
endtask

task automatic out_of_order_issue();
    logic [tag_w-1:0] t_add;
    logic [tag_w-1:0] t_xor;
    // short chain keeps the multiply waiting while the unit is free
    send(op_add, 5'd21, 5'd1, 5'd2);
    send(op_add, 5'd22, 5'd21, 5'd3);
    send(op_mul, 5'd23, 5'd22, 5'd4);
    send(op_add, 5'd24, 5'd23, 5'd1);
    t_add = last_tag;
    send(op_xor, 5'd25, 5'd5, 5'd6);
    t_xor = last_tag;
    wait_idle();
    check(32'(seen_cycle[t_xor] < seen_cycle[t_add]), 32'd1, "xor ahead of dependent add");
endtask

task automatic fill_station();
    int d0;
    int r0;
    int pick;
    logic [reg_addr_w-1:0] rd;
    logic [reg_addr_w-1:0] ra;
    logic [reg_addr_w-1:0] rb;
    d0 = n_dispatch;
    r0 = n_result;
    saw_full = 1'b0;
    for (int i = 0; i < 12; i++) begin
        pick = {$random(seed)} % 4;
        rd = 5'(26 + {$random(seed)} % 4);
        ra = 5'(1 + {$random(seed)} % 29);
        rb = 5'(1 + {$random(seed)} % 29);
        case (pick)
            2:       send(op_add, rd, ra, rb);
            3:       send(op_xor, rd, ra, rb);
            default: send(op_mul, rd, ra, rb);
        endcase
    end
    wait_idle();
    check(32'(saw_full), 32'd1, "instr_ready low with a full station");
    check(n_result - r0, n_dispatch - d0, "results of the full-station stream");
endtask

task automatic x0_and_waw();
    send(op_add, 5'd0, 5'd1, 5'd2);
    send(op_add, 5'd30, 5'd0, 5'd1);
    // older multiply waits on x30 and finishes after the younger writer
    send(op_mul, 5'd31, 5'd30, 5'd10);
    send(op_add, 5'd31, 5'd1, 5'd2);
    send(op_or, 5'd30, 5'd31, 5'd0);
    wait_idle();
    send(op_or, 5'd29, 5'd31, 5'd0);
    wait_idle();
endtask

task automatic flush_midway();
    logic [xlen-1:0] saved [2**reg_addr_w];
    int r0;
    wait_idle();
    saved = model_regs;
    send(op_mul, 5'd20, 5'd3, 5'd4);
    send(op_add, 5'd21, 5'd20, 5'd1);
    @(negedge clk);
    flush = 1'b1;
    for (int t = 0; t < 2**tag_w; t++) begin
        if (outstanding[t]) begin
            n_dropped++;
        end
        outstanding[t] = 1'b0;
    end
    model_regs = saved;
    tag_ctr = '0;
    r0 = n_result;
    @(negedge clk);
    flush = 1'b0;
    repeat (12) @(negedge clk);
    check(n_result - r0, 0, "results after flush");
    check(32'(instr_ready), 32'd1, "instr_ready after flush");
    send(op_add, 5'd22, 5'd20, 5'd21);
    send(op_sub, 5'd23, 5'd3, 5'd20);
    wait_idle();
endtask

//--- tests/tb_ooo_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ooo_core
    import ooo_pkg::*;
();

    logic   clk = 1'b0;
    logic   rst;
    logic   flush;
    logic   instr_valid;
    instr_t instr;
    logic   instr_ready;
    cdb_t   cdb_out;

    // reference model indexed by tag
    logic [xlen-1:0]       model_regs [2**reg_addr_w];
    logic [xlen-1:0]       exp_data [2**tag_w];
    logic [reg_addr_w-1:0] exp_rd [2**tag_w];
    logic                  outstanding [2**tag_w];
    int                    sent_cycle [2**tag_w];
    int                    seen_cycle [2**tag_w];
    logic [tag_w-1:0]      tag_ctr;
    logic [tag_w-1:0]      last_tag;
    logic                  saw_full;
    int                    cycle_cnt = 0;
    int                    n_dispatch = 0;
    int                    n_result = 0;
    int                    n_dropped = 0;
    int                    errors = 0;
    integer                seed = 53344;

    always #2 clk = ~clk;

    ooo_core_top dut_i (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_ready (instr_ready),
        .cdb_out     (cdb_out)
    );

    function automatic logic [xlen-1:0] expected_result(
        input alu_op_t op, input logic [xlen-1:0] a, input logic [xlen-1:0] b);
        case (op)
            op_add:  return a + b;
            op_sub:  return a - b;
            op_and:  return a & b;
            op_or:   return a | b;
            op_xor:  return a ^ b;
            op_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            op_mul:  return a * b;
            default: return 32'd1;
        endcase
    endfunction

    // one strobe after waiting for room in the station
    task automatic send(input alu_op_t op, input logic [reg_addr_w-1:0] rd,
                        input logic [reg_addr_w-1:0] rs1, input logic [reg_addr_w-1:0] rs2);
        while (!instr_ready) begin
            saw_full = 1'b1;
            @(negedge clk);
        end
        instr_valid = 1'b1;
        instr = '{op: op, rd: rd, rs1: rs1, rs2: rs2};
        exp_data[tag_ctr] = expected_result(op, model_regs[rs1], model_regs[rs2]);
        exp_rd[tag_ctr] = rd;
        outstanding[tag_ctr] = 1'b1;
        // the next rising edge samples the strobe
        sent_cycle[tag_ctr] = cycle_cnt + 1;
        if (rd != '0) begin
            model_regs[rd] = exp_data[tag_ctr];
        end
        last_tag = tag_ctr;
        tag_ctr = tag_ctr + 1'b1;
        n_dispatch++;
        @(negedge clk);
        instr_valid = 1'b0;
    endtask

    // CDB monitor sampling mid-cycle
    task automatic watch_cdb();
        forever begin
            @(negedge clk);
            if (cdb_out.valid && !rst) begin
                n_result++;
                seen_cycle[cdb_out.tag] = cycle_cnt + 1;
                if (!outstanding[cdb_out.tag]) begin
                    errors++;
                    $display("unexpected CDB result for tag %0d at %0t", cdb_out.tag, $time);
                end else begin
                    check(32'(cdb_out.rd), 32'(exp_rd[cdb_out.tag]), "result rd");
                    check(cdb_out.data, exp_data[cdb_out.tag], "result data");
                end
                outstanding[cdb_out.tag] = 1'b0;
            end
        end
    endtask

    task automatic wait_idle();
        logic busy;
        busy = 1'b1;
        while (busy) begin
            @(negedge clk);
            busy = 1'b0;
            for (int t = 0; t < 2**tag_w; t++) begin
                busy |= outstanding[t];
            end
        end
        repeat (2) @(negedge clk);
    endtask

    // limit grows with the number of dispatched instructions
    task automatic count_cycles();
        while (cycle_cnt < 20 * n_dispatch + 200) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout after %0d cycles, results still missing", cycle_cnt);
        $display("** FAIL **");
        $finish;
    endtask

    initial begin
        rst = 1'b1;
        flush = 1'b0;
        instr_valid = 1'b0;
        instr = '0;
        tag_ctr = '0;
        saw_full = 1'b0;
        for (int i = 0; i < 2**reg_addr_w; i++) begin
            model_regs[i] = '0;
        end
        for (int t = 0; t < 2**tag_w; t++) begin
            outstanding[t] = 1'b0;
            seen_cycle[t] = 0;
        end
        fork
            watch_cdb();
            count_cycles();
        join_none
        repeat (8) @(negedge clk);
        rst = 1'b0;
        check(32'(instr_ready), 32'd1, "instr_ready after reset");
        check(32'(cdb_out.valid), 32'd0, "cdb valid after reset");
        preload_regs();
        independent_ops();
        dependency_chains();
        out_of_order_issue();
        fill_station();
        x0_and_waw();
        flush_midway();
        wait_idle();
        check(n_result, n_dispatch - n_dropped, "total result count");
        $display("errors: %0d, dispatched: %0d, dropped: %0d, results: %0d",
                 errors, n_dispatch, n_dropped, n_result);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    `include "tb_ooo_tasks.svh"

endmodule

`default_nettype wire

//--- src/ooo_core_top.sv
`timescale 1ns/1ps
`default_nettype none

module ooo_core_top
    import ooo_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   flush,
    input  logic   instr_valid,
    input  instr_t instr,
    output logic   instr_ready,
    output cdb_t   cdb_out
);

    rs_entry_t rs_write;
    logic      rs_free;
    issue_t    issue;
    logic      exe_busy;

    // producer side, register file and status table
    dispatch_unit dispatch_i (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .instr_valid (instr_valid),
        .instr       (instr),
        .rs_free     (rs_free),
        .cdb         (cdb_out),
        .rs_write    (rs_write),
        .instr_ready (instr_ready)
    );

    reservation_station station_i (
        .clk      (clk),
        .rst      (rst),
        .flush    (flush),
        .rs_write (rs_write),
        .cdb      (cdb_out),
        .exe_busy (exe_busy),
        .rs_free  (rs_free),
        .issue    (issue)
    );

    // the only CDB driver
    execute_unit execute_i (
        .clk      (clk),
        .rst      (rst),
        .flush    (flush),
        .issue    (issue),
        .exe_busy (exe_busy),
        .cdb      (cdb_out)
    );

endmodule

`default_nettype wire

//--- src/execute_unit.sv
`timescale 1ns/1ps
`default_nettype none

module execute_unit
    import ooo_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   flush,
    input  issue_t issue,
    output logic   exe_busy,
    output cdb_t   cdb
);

    logic [mul_cnt_w-1:0]  mul_cnt;
    logic [xlen-1:0]       mul_data;
    logic [tag_w-1:0]      mul_tag;
    logic [reg_addr_w-1:0] mul_rd;
    logic [xlen-1:0]       product;
    logic [xlen-1:0]       alu_result;
    logic                  alu_fire;
    logic                  mul_fire;
    cdb_t                  cdb_next;

    assign alu_fire = issue.valid && (issue.op != op_mul);
    assign mul_fire = issue.valid && (issue.op == op_mul);

    // low half of the product only
    assign product = issue.a * issue.b;

    // busy covers the accept cycle too, so the station cannot slip one in
    assign exe_busy = mul_fire || (mul_cnt != '0);

    always_comb begin
        case (issue.op)
            op_add:  alu_result = issue.a + issue.b;
            op_sub:  alu_result = issue.a - issue.b;
            op_and:  alu_result = issue.a & issue.b;
            op_or:   alu_result = issue.a | issue.b;
            op_xor:  alu_result = issue.a ^ issue.b;
            op_slt:  alu_result = {{(xlen-1){1'b0}}, $signed(issue.a) < $signed(issue.b)};
            op_li1:  alu_result = {{(xlen-1){1'b0}}, 1'b1};
            default: alu_result = '0;
        endcase
    end

    always_comb begin
        cdb_next.valid = alu_fire;
        cdb_next.tag   = issue.tag;
        cdb_next.rd    = issue.rd;
        cdb_next.data  = alu_result;
        // last multiply cycle
        if (mul_cnt == mul_cnt_w'(1)) begin
            cdb_next.valid = 1'b1;
            cdb_next.tag   = mul_tag;
            cdb_next.rd    = mul_rd;
            cdb_next.data  = mul_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            mul_cnt <= '0;
        end else if (mul_fire) begin
            mul_cnt <= mul_cnt_w'(mul_latency - 1);
        end else if (mul_cnt != '0) begin
            mul_cnt <= mul_cnt - 1'b1;
        end
    end

    // multiply holding register
    always_ff @(posedge clk) begin
        if (mul_fire) begin
            mul_data <= product;
            mul_tag  <= issue.tag;
            mul_rd   <= issue.rd;
        end
    end

    always_ff @(posedge clk) begin
        cdb <= cdb_next;
        if (rst || flush) begin
            cdb.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- src/reservation_station.sv
`timescale 1ns/1ps
`default_nettype none

module reservation_station
    import ooo_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      flush,
    input  rs_entry_t rs_write,
    input  cdb_t      cdb,
    input  logic      exe_busy,
    output logic      rs_free,
    output issue_t    issue
);

    rs_entry_t slots [rs_depth];

    logic [$clog2(rs_depth)-1:0] wr_idx;
    logic [$clog2(rs_depth)-1:0] sel_idx;
    logic                        sel_found;
    logic [age_w-1:0]            best_age;
    logic [age_w-1:0]            age_diff;
    logic                        issue_fire;
    int unsigned                 free_cnt;
    rs_entry_t                   wr_entry;
    issue_t                      issue_next;

    // operand capture from a CDB result
    function automatic rs_entry_t capture(input rs_entry_t e, input cdb_t c);
        rs_entry_t r;
        r = e;
        if (c.valid && !e.src1_ready && (e.src1_tag == c.tag)) begin
            r.src1_ready = 1'b1;
            r.src1_data  = c.data;
        end
        if (c.valid && !e.src2_ready && (e.src2_tag == c.tag)) begin
            r.src2_ready = 1'b1;
            r.src2_data  = c.data;
        end
        return r;
    endfunction

    // lowest empty slot and number of empty slots
    always_comb begin
        wr_idx   = '0;
        free_cnt = 0;
        for (int i = rs_depth - 1; i >= 0; i--) begin
            if (!slots[i].valid) begin
                wr_idx   = i[$clog2(rs_depth)-1:0];
                free_cnt = free_cnt + 1;
            end
        end
    end

    // the entry still in flight from dispatch takes one of the free slots
    assign rs_free = free_cnt > (rs_write.valid ? 1 : 0);

    assign wr_entry = capture(rs_write, cdb);

    // oldest ready entry
    // ages are compared by the sign of their difference, the in-flight
    // window is far below half the age range
    always_comb begin
        sel_idx   = '0;
        sel_found = 1'b0;
        best_age  = '0;
        age_diff  = '0;
        for (int i = 0; i < rs_depth; i++) begin
            age_diff = slots[i].age - best_age;
            if (slots[i].valid && slots[i].src1_ready && slots[i].src2_ready) begin
                if (!sel_found || age_diff[age_w-1]) begin
                    sel_idx   = i[$clog2(rs_depth)-1:0];
                    sel_found = 1'b1;
                    best_age  = slots[i].age;
                end
            end
        end
    end

    assign issue_fire = sel_found && !exe_busy;

    always_comb begin
        issue_next       = '0;
        issue_next.valid = issue_fire;
        issue_next.op    = slots[sel_idx].op;
        issue_next.rd    = slots[sel_idx].rd;
        issue_next.tag   = slots[sel_idx].tag;
        issue_next.a     = slots[sel_idx].src1_data;
        issue_next.b     = slots[sel_idx].src2_data;
    end

    always_ff @(posedge clk) begin
        issue <= issue_next;
        if (rst || flush) begin
            issue.valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            for (int i = 0; i < rs_depth; i++) begin
                slots[i].valid <= 1'b0;
            end
        end else begin
            for (int i = 0; i < rs_depth; i++) begin
                if (slots[i].valid) begin
                    slots[i] <= capture(slots[i], cdb);
                end
            end
            // issued entry leaves at the same edge
            if (issue_fire) begin
                slots[sel_idx].valid <= 1'b0;
            end
            // write slot is always empty, so it never collides with issue
            if (rs_write.valid) begin
                slots[wr_idx] <= wr_entry;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/dispatch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module dispatch_unit
    import ooo_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      flush,
    input  logic      instr_valid,
    input  instr_t    instr,
    input  logic      rs_free,
    input  cdb_t      cdb,
    output rs_entry_t rs_write,
    output logic      instr_ready
);

    // architectural state
    logic [xlen-1:0]         regs [2**reg_addr_w];
    logic [2**reg_addr_w-1:0] pending;
    logic [tag_w-1:0]        stat_tag [2**reg_addr_w];

    logic [tag_w-1:0] next_tag;
    logic [age_w-1:0] next_age;
    logic             fire;
    logic             cdb_hit;
    rs_entry_t        entry_next;

    assign instr_ready = rs_free;
    assign fire = instr_valid && rs_free;

    // result only lands if it still belongs to the newest writer
    assign cdb_hit = cdb.valid && (cdb.rd != '0) && pending[cdb.rd]
                     && (stat_tag[cdb.rd] == cdb.tag);

    // operand lookup with same-cycle bypass from the CDB
    function automatic void lookup(
        input  logic [reg_addr_w-1:0] ra,
        output logic                  rdy,
        output logic [tag_w-1:0]      tg,
        output logic [xlen-1:0]       dat
    );
        rdy = 1'b1;
        tg  = stat_tag[ra];
        dat = regs[ra];
        if (ra == '0) begin
            dat = '0;
        end else if (pending[ra]) begin
            if (cdb.valid && (cdb.tag == stat_tag[ra])) begin
                dat = cdb.data;
            end else begin
                rdy = 1'b0;
            end
        end
    endfunction

    always_comb begin
        entry_next       = '0;
        entry_next.valid = fire;
        entry_next.op    = instr.op;
        entry_next.rd    = instr.rd;
        entry_next.tag   = next_tag;
        entry_next.age   = next_age;
        lookup(instr.rs1, entry_next.src1_ready, entry_next.src1_tag, entry_next.src1_data);
        lookup(instr.rs2, entry_next.src2_ready, entry_next.src2_tag, entry_next.src2_data);
        // li1 ignores its sources
        if (instr.op == op_li1) begin
            entry_next.src1_ready = 1'b1;
            entry_next.src2_ready = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        rs_write <= entry_next;
        if (rst || flush) begin
            rs_write.valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            next_tag <= '0;
            next_age <= '0;
        end else if (fire) begin
            next_tag <= next_tag + 1'b1;
            next_age <= next_age + 1'b1;
        end
    end

    // register file keeps its values across a flush
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 2**reg_addr_w; i++) begin
                regs[i] <= '0;
            end
        end else if (cdb_hit) begin
            regs[cdb.rd] <= cdb.data;
        end
    end

    // status table, a newer writer overrides the clear
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            pending <= '0;
        end else begin
            if (cdb_hit) begin
                pending[cdb.rd] <= 1'b0;
            end
            if (fire && (instr.rd != '0)) begin
                pending[instr.rd] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fire && (instr.rd != '0)) begin
            stat_tag[instr.rd] <= next_tag;
        end
    end

endmodule

`default_nettype wire

//--- src/ooo_pkg.sv
`default_nettype none

package ooo_pkg;

    localparam int xlen        = 32;
    localparam int reg_addr_w  = 5;
    // tags wrap after 16 instructions
    localparam int tag_w       = 4;
    localparam int rs_depth    = 4;
    localparam int age_w       = 8;
    localparam int mul_latency = 4;
    // multiply down-counter, wide enough to hold mul_latency
    localparam int mul_cnt_w   = $clog2(mul_latency) + 1;

    typedef enum logic [2:0] {
        op_add = 3'd0,
        op_sub = 3'd1,
        op_and = 3'd2,
        op_or  = 3'd3,
        op_xor = 3'd4,
        op_slt = 3'd5,
        op_mul = 3'd6,
        // constant 1, needs no sources
        op_li1 = 3'd7
    } alu_op_t;

    typedef struct packed {
        alu_op_t               op;
        logic [reg_addr_w-1:0] rd;
        logic [reg_addr_w-1:0] rs1;
        logic [reg_addr_w-1:0] rs2;
    } instr_t;

    typedef struct packed {
        logic                  valid;
        alu_op_t               op;
        logic [reg_addr_w-1:0] rd;
        logic [tag_w-1:0]      tag;
        logic [age_w-1:0]      age;
        logic                  src1_ready;
        logic [tag_w-1:0]      src1_tag;
        logic [xlen-1:0]       src1_data;
        logic                  src2_ready;
        logic [tag_w-1:0]      src2_tag;
        logic [xlen-1:0]       src2_data;
    } rs_entry_t;

    typedef struct packed {
        logic                  valid;
        logic [tag_w-1:0]      tag;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       data;
    } cdb_t;

    typedef struct packed {
        logic                  valid;
        alu_op_t               op;
        logic [reg_addr_w-1:0] rd;
        logic [tag_w-1:0]      tag;
        logic [xlen-1:0]       a;
        logic [xlen-1:0]       b;
    } issue_t;

endpackage

`default_nettype wire
